//--- hdl/isa_pkg.sv
// isa_pkg: data widths, opcodes, function codes, instruction formats and the instruction union
`default_nettype none

package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // only the opcodes this slice executes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;  // also addi
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_ALT     = 7'b0100000;  // sub / sra

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    // branch offset bits sit in the funct7 and rd slots of the r view
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

    localparam logic [XLEN-1:0] INST_NOP = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire

//--- hdl/pipe_pkg.sv
// pipe_pkg: operation encoding, hold flags, id_ex payload, write-back and redirect structs
`default_nettype none

package pipe_pkg;

    localparam int BR_OFF_W = 13;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_BEQ,
        ALU_BNE
    } alu_op_e;

    typedef enum logic [1:0] {
        HOLD_NONE,
        HOLD_STALL,
        HOLD_CLEAR
    } hold_e;

    typedef struct packed {
        logic                          valid;
        alu_op_e                       op;
        logic [isa_pkg::XLEN-1:0]      pc;
        logic [isa_pkg::XLEN-1:0]      op1;
        logic [isa_pkg::XLEN-1:0]      op2;     // imm for addi, shamt in [4:0]
        logic                          reg_we;
        logic [isa_pkg::REG_ADDR_W-1:0] waddr;
        logic [BR_OFF_W-1:0]           br_off;
    } id_ex_t;

    typedef struct packed {
        logic                           valid;
        logic [isa_pkg::REG_ADDR_W-1:0] waddr;
        logic [isa_pkg::XLEN-1:0]       wdata;
    } wb_t;

    typedef struct packed {
        logic                     taken;
        logic [isa_pkg::XLEN-1:0] target;
    } branch_t;

    localparam id_ex_t ID_EX_EMPTY = '0;

endpackage

`default_nettype wire

//--- hdl/reg_file.sv
// reg_file: 32 x 32 register file, x0 reads zero, two async read ports, one write port
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic [isa_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [isa_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [isa_pkg::XLEN-1:0]       rdata1_o,
    output logic [isa_pkg::XLEN-1:0]       rdata2_o,
    input  pipe_pkg::wb_t                  wb_i
);
    import isa_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && (wb_i.waddr != '0)) begin  // x0 never written
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- hdl/inst_decode.sv
// inst_decode: instruction decode into the id_ex payload, with operand forwarding
`timescale 1ns/100ps
`default_nettype none

module inst_decode (
    input  logic                           inst_valid_i,
    input  isa_pkg::inst_u                 inst_i,
    input  logic [isa_pkg::XLEN-1:0]       pc_i,
    input  logic [isa_pkg::XLEN-1:0]       rdata1_i,
    input  logic [isa_pkg::XLEN-1:0]       rdata2_i,
    input  pipe_pkg::wb_t                  fwd_i,
    input  pipe_pkg::wb_t                  wb_i,
    output logic [isa_pkg::REG_ADDR_W-1:0] raddr1_o,
    output logic [isa_pkg::REG_ADDR_W-1:0] raddr2_o,
    output pipe_pkg::id_ex_t               payload_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    inst_u   w;  // word actually decoded, nop when unsupported
    alu_op_e op;
    logic    is_imm;
    logic    is_br;

    // youngest in-flight result wins
    function automatic logic [XLEN-1:0] fwd_sel(input logic [REG_ADDR_W-1:0] addr,
                                                input logic [XLEN-1:0] rf, input wb_t f,
                                                input wb_t b);
        logic [XLEN-1:0] val;
        val = rf;
        if (b.valid && (b.waddr == addr) && (addr != '0)) val = b.wdata;
        if (f.valid && (f.waddr == addr) && (addr != '0)) val = f.wdata;
        return val;
    endfunction

    always_comb begin
        w  = inst_i;
        op = ALU_ADD;
        case (inst_i.r.opcode)
            OPC_OP: begin
                case (inst_i.r.funct3)
                    F3_ADD_SUB: op = (inst_i.r.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     op = ALU_SLL;
                    F3_SLT:     op = ALU_SLT;
                    F3_XOR:     op = ALU_XOR;
                    F3_SRL: begin
                        if (inst_i.r.funct7 == F7_ALT) w = INST_NOP;  // no sra
                        else op = ALU_SRL;
                    end
                    F3_OR:      op = ALU_OR;
                    F3_AND:     op = ALU_AND;
                    default:    w  = INST_NOP;  // sltu
                endcase
            end
            OPC_OP_IMM: if (inst_i.i.funct3 != F3_ADD_SUB) w = INST_NOP;  // addi only
            OPC_BRANCH: begin
                case (inst_i.r.funct3)
                    F3_BEQ:  op = ALU_BEQ;
                    F3_BNE:  op = ALU_BNE;
                    default: w  = INST_NOP;
                endcase
            end
            default: w = INST_NOP;
        endcase
    end

    assign is_imm   = w.i.opcode == OPC_OP_IMM;
    assign is_br    = w.r.opcode == OPC_BRANCH;
    assign raddr1_o = w.r.rs1;
    assign raddr2_o = w.r.rs2;

    assign payload_o.valid  = inst_valid_i;
    assign payload_o.op     = op;
    assign payload_o.pc     = pc_i;
    assign payload_o.op1    = fwd_sel(w.r.rs1, rdata1_i, fwd_i, wb_i);
    assign payload_o.op2    = is_imm ? {{(XLEN-12){w.i.imm12[11]}}, w.i.imm12}
                                     : fwd_sel(w.r.rs2, rdata2_i, fwd_i, wb_i);
    assign payload_o.reg_we = !is_br && (w.r.rd != '0);  // rd x0 writes nothing
    assign payload_o.waddr  = w.r.rd;
    assign payload_o.br_off = {w.r.funct7[6], w.r.rd[0], w.r.funct7[5:0], w.r.rd[4:1], 1'b0};

endmodule

`default_nettype wire

//--- hdl/id_ex.sv
// id_ex: decode-to-execute pipeline register with enable, stall and clear
`timescale 1ns/100ps
`default_nettype none

module id_ex (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  pipe_pkg::id_ex_t payload_i,
    input  logic             ready_i,
    input  pipe_pkg::hold_e  hold_i,
    output pipe_pkg::id_ex_t ex_o
);
    import pipe_pkg::*;

    id_ex_t ex_q;
    logic   load;

    assign load = (hold_i == HOLD_NONE) && ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_q <= ID_EX_EMPTY;
        end else if (hold_i == HOLD_CLEAR) begin  // squash after taken branch or shift end
            ex_q <= ID_EX_EMPTY;
        end else if (load) begin
            ex_q <= payload_i.valid ? payload_i : ID_EX_EMPTY;  // bubble when no strobe
        end
    end

    assign ex_o = ex_q;

endmodule

`default_nettype wire

//--- hdl/shift_counter.sv
// shift_counter: loadable down-counter timing an iterative shift
`timescale 1ns/100ps
`default_nettype none

module shift_counter (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       load_i,
    input  logic [4:0] amount_i,
    output logic       done_o
);

    logic [4:0] count_q;
    logic       active_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q  <= '0;
            active_q <= 1'b0;
        end else if (load_i) begin
            count_q  <= amount_i - 5'd1;  // last step is taken in the done cycle
            active_q <= 1'b1;
        end else if (active_q) begin
            if (count_q == '0) active_q <= 1'b0;
            else count_q <= count_q - 5'd1;
        end
    end

    assign done_o = active_q && (count_q == '0);

endmodule

`default_nettype wire

//--- hdl/stage_ctrl.sv
// stage_ctrl: run/shift FSM driving ready, hold flags and shift control
`timescale 1ns/100ps
`default_nettype none

module stage_ctrl (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  pipe_pkg::id_ex_t ex_i,
    input  logic             branch_taken_i,
    input  logic             shift_done_i,
    output logic             ready_o,
    output pipe_pkg::hold_e  hold_o,
    output logic             shift_load_o,
    output logic             shift_busy_o
);
    import pipe_pkg::*;

    typedef enum logic {ST_RUN, ST_SHIFT} state_e;

    state_e state_q;
    state_e state_d;
    logic   long_shift;

    assign long_shift = ex_i.valid && ((ex_i.op == ALU_SLL) || (ex_i.op == ALU_SRL))
                        && (ex_i.op2[4:0] != '0);  // shamt 0 is single cycle

    always_comb begin
        state_d      = state_q;
        ready_o      = 1'b1;
        hold_o       = HOLD_NONE;
        shift_load_o = 1'b0;
        case (state_q)
            ST_RUN: begin
                if (branch_taken_i) begin
                    ready_o = 1'b0;
                    hold_o  = HOLD_CLEAR;  // drop the branch, redirect next cycle
                end else if (long_shift) begin
                    ready_o      = 1'b0;
                    hold_o       = HOLD_STALL;
                    shift_load_o = 1'b1;
                    state_d      = ST_SHIFT;
                end
            end
            default: begin
                ready_o = 1'b0;
                hold_o  = shift_done_i ? HOLD_CLEAR : HOLD_STALL;
                if (shift_done_i) state_d = ST_RUN;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) state_q <= ST_RUN;
        else state_q <= state_d;
    end

    assign shift_busy_o = state_q == ST_SHIFT;

endmodule

`default_nettype wire

//--- hdl/exec_unit.sv
// exec_unit: ALU, branch compare, iterative shifter, write-back and redirect registers
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  pipe_pkg::id_ex_t  ex_i,
    input  logic              shift_load_i,
    input  logic              shift_busy_i,
    input  logic              shift_done_i,
    output pipe_pkg::wb_t     fwd_o,
    output pipe_pkg::wb_t     wb_o,
    output logic              branch_taken_o,
    output pipe_pkg::branch_t branch_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic            long_shift;
    logic            op_eq;
    logic [XLEN-1:0] acc_q;
    logic [XLEN-1:0] acc_next;
    logic [XLEN-1:0] result;

    assign long_shift = ((ex_i.op == ALU_SLL) || (ex_i.op == ALU_SRL)) && (ex_i.op2[4:0] != '0);
    assign acc_next   = (ex_i.op == ALU_SRL) ? (acc_q >> 1) : (acc_q << 1);  // one bit per step
    assign op_eq      = ex_i.op1 == ex_i.op2;

    always_comb begin
        case (ex_i.op)
            ALU_ADD:          result = ex_i.op1 + ex_i.op2;
            ALU_SUB:          result = ex_i.op1 - ex_i.op2;
            ALU_AND:          result = ex_i.op1 & ex_i.op2;
            ALU_OR:           result = ex_i.op1 | ex_i.op2;
            ALU_XOR:          result = ex_i.op1 ^ ex_i.op2;
            ALU_SLT:          result = {{(XLEN-1){1'b0}}, $signed(ex_i.op1) < $signed(ex_i.op2)};
            ALU_SLL, ALU_SRL: result = long_shift ? acc_next : ex_i.op1;
            default:          result = '0;
        endcase
    end

    assign branch_taken_o = ex_i.valid && (((ex_i.op == ALU_BEQ) && op_eq) ||
                                           ((ex_i.op == ALU_BNE) && !op_eq));

    // long shift result only counts in its final cycle
    assign fwd_o.valid = ex_i.valid && ex_i.reg_we && (!long_shift || shift_done_i);
    assign fwd_o.waddr = ex_i.waddr;
    assign fwd_o.wdata = result;

    always_ff @(posedge clk_i) begin
        if (shift_load_i) acc_q <= ex_i.op1;
        else if (shift_busy_i) acc_q <= acc_next;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_o     <= '0;
            branch_o <= '0;
        end else begin
            wb_o            <= fwd_o;
            branch_o.taken  <= branch_taken_o;
            branch_o.target <= ex_i.pc + {{(XLEN-BR_OFF_W){ex_i.br_off[BR_OFF_W-1]}}, ex_i.br_off};
        end
    end

endmodule

`default_nettype wire

//--- hdl/core_ex_top.sv
// core_ex_top: decode-to-execute slice top level
`timescale 1ns/100ps
`default_nettype none

module core_ex_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     inst_valid_i,
    input  isa_pkg::inst_u           inst_i,
    input  logic [isa_pkg::XLEN-1:0] pc_i,
    output logic                     ready_o,
    output pipe_pkg::wb_t            wb_o,
    output pipe_pkg::branch_t        branch_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [REG_ADDR_W-1:0] raddr1;
    logic [REG_ADDR_W-1:0] raddr2;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;
    id_ex_t                payload;
    id_ex_t                ex;
    wb_t                   fwd;
    hold_e                 hold;
    logic                  shift_load;
    logic                  shift_busy;
    logic                  shift_done;
    logic                  branch_taken;

    reg_file reg_file_i (
        .clk_i, .arst_n_i,
        .raddr1_i(raddr1), .raddr2_i(raddr2),
        .rdata1_o(rdata1), .rdata2_o(rdata2),
        .wb_i    (wb_o)
    );

    inst_decode inst_decode_i (
        .inst_valid_i, .inst_i, .pc_i,
        .rdata1_i(rdata1), .rdata2_i(rdata2),
        .fwd_i   (fwd),    .wb_i    (wb_o),
        .raddr1_o(raddr1), .raddr2_o(raddr2),
        .payload_o(payload)
    );

    id_ex id_ex_i (
        .clk_i, .arst_n_i,
        .payload_i(payload), .ready_i(ready_o), .hold_i(hold),
        .ex_o     (ex)
    );

    stage_ctrl stage_ctrl_i (
        .clk_i, .arst_n_i,
        .ex_i(ex), .branch_taken_i(branch_taken), .shift_done_i(shift_done),
        .ready_o, .hold_o(hold), .shift_load_o(shift_load), .shift_busy_o(shift_busy)
    );

    shift_counter shift_counter_i (
        .clk_i, .arst_n_i,
        .load_i(shift_load), .amount_i(ex.op2[4:0]), .done_o(shift_done)
    );

    exec_unit exec_unit_i (
        .clk_i, .arst_n_i,
        .ex_i(ex), .shift_load_i(shift_load), .shift_busy_i(shift_busy),
        .shift_done_i(shift_done),
        .fwd_o(fwd), .wb_o, .branch_taken_o(branch_taken), .branch_o
    );

endmodule

`default_nettype wire

//--- testbench/tb_core_ex_tasks.svh
// testbench tasks: issue, write-back wait, compare tasks and directed tests

task automatic issue(input logic [31:0] word, output int acc_cyc);
    int waited;
    waited  = 0;
    acc_cyc = 0;
    if (timed_out) return;
    inst_valid_i = 1'b1;
    inst_i       = word;
    pc_i         = next_pc;
    while (!ready_o && waited < WAIT_LIMIT) begin  // word held while ready is low
        @(posedge clk_i);
        #10;
        waited++;
    end
    if (!ready_o) begin
        $display("timeout while waiting for the DUT to accept word %h", word);
        failures++;
        timed_out = 1'b1;
    end else begin
        @(posedge clk_i);
        #10;
        acc_cyc = cycle;
        next_pc = next_pc + 32'd4;
    end
    inst_valid_i = 1'b0;
endtask

task automatic check_wb(input string test, input wb_t exp, input wb_t act);
    if (act !== exp) begin
        $display("mismatch %s: expected %p actual %p", test, exp, act);
        mismatches++;
    end
endtask

task automatic check_branch(input string test, input branch_t exp, input branch_t act);
    if (act !== exp) begin
        $display("mismatch %s: expected %p actual %p", test, exp, act);
        mismatches++;
    end
endtask

task automatic check_flag(input string test, input logic exp, input logic act);
    if (act !== exp) begin
        $display("mismatch %s: expected %b actual %b", test, exp, act);
        mismatches++;
    end
endtask

task automatic check_count(input string test, input int exp, input int act);
    if (act != exp) begin
        $display("mismatch %s: expected %0d actual %0d", test, exp, act);
        mismatches++;
    end
endtask

task automatic expect_wb(input string test, input wb_t exp, output int wb_cyc);
    int waited;
    waited = 0;
    wb_cyc = 0;
    if (timed_out) return;
    while (wb_q.size() == 0 && waited < WAIT_LIMIT) begin
        @(posedge clk_i);
        #10;
        waited++;
    end
    if (wb_q.size() == 0) begin
        $display("timeout in %s while waiting for a write-back", test);
        failures++;
        timed_out = 1'b1;
    end else begin
        wb_cyc = wb_cyc_q.pop_front();
        check_wb(test, exp, wb_q.pop_front());
    end
endtask

// nothing may show up in an idle window
task automatic check_quiet(input string test);
    repeat (6) @(posedge clk_i);
    #10;
    check_count({test, " stray write-backs"}, 0, wb_q.size());
    check_count({test, " stray redirects"}, 0, br_q.size());
    wb_q.delete();
    wb_cyc_q.delete();
    br_q.delete();
endtask

task automatic test_reset_load();
    int          acc;
    int          wbc;
    logic [31:0] rnd;
    check_flag("reset ready", 1'b1, ready_o);
    check_quiet("reset");
    for (int r = 1; r < 32; r++) begin
        rnd = random_bits(12);
        shadow[r[4:0]] = {{20{rnd[11]}}, rnd[11:0]};
        issue(addi_word(r[4:0], 5'd0, rnd[11:0]), acc);
        expect_wb("addi load", {1'b1, r[4:0], shadow[r[4:0]]}, wbc);
    end
    check_quiet("addi load");
endtask

task automatic test_alu_ops();
    int          acc;
    int          wbc;
    logic [31:0] rnd;
    logic [3:0]  sel;
    logic [31:0] res;
    for (int k = 0; k < 24; k++) begin
        rnd = random_bits(18);
        sel = alu_choice(rnd[17:15]);
        res = alu_model(sel[2:0], sel[3], shadow[rnd[14:10]], shadow[rnd[9:5]]);
        issue(r_word(sel[3], rnd[9:5], rnd[14:10], sel[2:0], rnd[4:0]), acc);
        if (rnd[4:0] != 5'd0) begin  // rd x0 gives no write-back
            shadow[rnd[4:0]] = res;
            expect_wb("alu op", {1'b1, rnd[4:0], res}, wbc);
        end
    end
    issue(r_word(1'b0, 5'd2, 5'd1, 3'b110, 5'd0), acc);
    issue(r_word(1'b0, 5'd0, 5'd0, 3'b110, 5'd7), acc);
    shadow[7] = '0;
    expect_wb("x0 read", {1'b1, 5'd7, 32'd0}, wbc);
    check_quiet("alu ops");
endtask

task automatic test_forward_chain();
    wb_t         exp_q [$];
    int          acc_q [$];
    int          acc;
    int          wbc;
    int          low_before;
    logic [31:0] rnd;
    logic [3:0]  sel;
    logic [4:0]  prev;
    logic [4:0]  rd;
    logic [31:0] res;
    prev       = 5'd1;
    low_before = ready_low;
    for (int k = 0; k < 10; k++) begin
        rnd = random_bits(20);
        rd  = (rnd[4:0] == 5'd0) ? 5'd1 : rnd[4:0];
        if (!k[0]) begin
            sel = alu_choice(rnd[7:5]);
            res = alu_model(sel[2:0], sel[3], shadow[prev], shadow[rnd[12:8]]);
            issue(r_word(sel[3], rnd[12:8], prev, sel[2:0], rd), acc);
        end else begin
            res = shadow[prev] + {{20{rnd[19]}}, rnd[19:8]};
            issue(addi_word(rd, prev, rnd[19:8]), acc);
        end
        shadow[rd] = res;
        exp_q.push_back({1'b1, rd, res});
        acc_q.push_back(acc);
        prev = rd;  // next one reads this result
    end
    for (int k = 0; k < 10; k++) begin
        expect_wb("forward chain", exp_q.pop_front(), wbc);
        check_count("forward latency", acc_q.pop_front() + 1, wbc);
    end
    check_count("forward ready drops", low_before, ready_low);
    check_quiet("forward chain");
endtask

task automatic test_shifts();
    int          acc;
    int          acc_next;
    int          wbc;
    logic [31:0] rnd;
    logic [4:0]  shamt;
    logic [4:0]  rd;
    logic [31:0] res;
    for (int k = 0; k < 8; k++) begin
        rnd        = random_bits(15);
        shamt      = (k == 0) ? 5'd0 : rnd[4:0];
        rd         = (rnd[14:10] == 5'd0) ? 5'd5 : rnd[14:10];
        shadow[30] = {27'd0, shamt};
        issue(addi_word(5'd30, 5'd0, {7'd0, shamt}), acc);
        expect_wb("shift amount", {1'b1, 5'd30, shadow[30]}, wbc);
        res = k[0] ? (shadow[rnd[9:5]] >> shamt) : (shadow[rnd[9:5]] << shamt);
        issue(r_word(1'b0, 5'd30, rnd[9:5], k[0] ? 3'b101 : 3'b001, rd), acc);
        issue(addi_word(5'd28, 5'd0, k[11:0] + 12'd1), acc_next);  // offered during the shift
        shadow[rd] = res;
        expect_wb("shift result", {1'b1, rd, res}, wbc);
        check_count("shift latency", acc + int'(shamt) + 1, wbc);
        check_count("word offered during shift",
                    (shamt == 5'd0) ? acc + 1 : acc + int'(shamt) + 2, acc_next);
        shadow[28] = k + 1;
        expect_wb("shift marker", {1'b1, 5'd28, shadow[28]}, wbc);
    end
    check_quiet("shifts");
endtask

task automatic test_branches();
    int          acc;
    int          wbc;
    logic [31:0] rnd;
    logic [12:0] off;
    logic [31:0] target;
    logic        same;
    logic        taken;
    rnd        = random_bits(12);
    shadow[26] = {{20{rnd[11]}}, rnd[11:0]};
    shadow[27] = shadow[26] ^ 32'd1;  // differs from x26 in bit 0
    issue(addi_word(5'd26, 5'd0, rnd[11:0]), acc);
    expect_wb("branch setup", {1'b1, 5'd26, shadow[26]}, wbc);
    issue(addi_word(5'd27, 5'd0, rnd[11:0] ^ 12'd1), acc);
    expect_wb("branch setup", {1'b1, 5'd27, shadow[27]}, wbc);
    for (int k = 0; k < 8; k++) begin
        rnd    = random_bits(12);
        same   = k[1];
        taken  = k[0] ? same : !same;  // beq on odd k, bne on even k
        off    = {rnd[11:0], 1'b0};
        target = next_pc + {{19{off[12]}}, off};
        issue(branch_word(k[0] ? 3'b000 : 3'b001, 5'd26, same ? 5'd26 : 5'd27, off), acc);
        if (taken) next_pc = target;  // fetch follows the redirect
        shadow[25] = k + 1;
        issue(addi_word(5'd25, 5'd0, k[11:0] + 12'd1), acc);
        expect_wb("branch next", {1'b1, 5'd25, shadow[25]}, wbc);
        check_count("redirect count", taken ? 1 : 0, br_q.size());
        if (br_q.size() != 0) check_branch("branch target", {1'b1, target}, br_q.pop_front());
    end
    check_quiet("branches");
endtask

//--- testbench/tb_core_ex.sv
// tb_core_ex: clock, reset, LFSR, instruction encoders, DUT instance, output monitor, test sequence
`timescale 1ns/100ps
`default_nettype none

module tb_core_ex;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int WAIT_LIMIT = 64;  // cycles per wait loop

    logic                clk_i;
    logic                arst_n_i;
    logic                inst_valid_i;
    inst_u               inst_i;
    logic [XLEN-1:0]     pc_i;
    logic                ready_o;
    wb_t                 wb_o;
    branch_t             branch_o;

    logic [XLEN-1:0]     shadow [32];  // register model
    logic [31:0]         lfsr_q = 32'd84494;
    logic [XLEN-1:0]     next_pc = 32'h0000_1000;
    int                  cycle = 0;
    int                  ready_low = 0;  // cycles with ready_o low
    int                  mismatches = 0;
    int                  failures = 0;
    logic                timed_out = 1'b0;
    wb_t                 wb_q [$];
    int                  wb_cyc_q [$];
    branch_t             br_q [$];

    core_ex_top core_ex_top_i (
        .clk_i, .arst_n_i, .inst_valid_i, .inst_i, .pc_i, .ready_o, .wb_o, .branch_o
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle <= cycle + 1;

    // outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            if (wb_o.valid) begin
                wb_q.push_back(wb_o);
                wb_cyc_q.push_back(cycle);
            end
            if (branch_o.taken) br_q.push_back(branch_o);
            if (!ready_o) ready_low++;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    function automatic logic [31:0] r_word(input logic alt, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    // B-type immediate scatter
    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // one of the six register-form ops as {alt, funct3}
    function automatic logic [3:0] alu_choice(input logic [2:0] n);
        case (n)
            3'd0:    return 4'b0000;  // add
            3'd1:    return 4'b1000;  // sub
            3'd2:    return 4'b0111;  // and
            3'd3:    return 4'b0110;  // or
            3'd4:    return 4'b0100;  // xor
            default: return 4'b0010;  // slt
        endcase
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    `include "tb_core_ex_tasks.svh"

    initial begin
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = INST_NOP;
        pc_i         = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk_i);
        #10;
        arst_n_i = 1'b1;
        test_reset_load();
        if (!timed_out) test_alu_ops();
        if (!timed_out) test_forward_chain();
        if (!timed_out) test_shifts();
        if (!timed_out) test_branches();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- core_ex_top.f
+incdir+testbench
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/reg_file.sv
hdl/inst_decode.sv
hdl/id_ex.sv
hdl/shift_counter.sv
hdl/stage_ctrl.sv
hdl/exec_unit.sv
hdl/core_ex_top.sv
testbench/tb_core_ex.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_core_ex -f core_ex_top.f -o sim_core_ex \
    && ./obj_dir/sim_core_ex | tee /dev/stderr | grep -qx "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
